// ==== cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Port widths, shared by front end and memory side
`define CACHE_ADDR_W        16   // Byte address
`define CACHE_DATA_W        32   // Word
`define CACHE_NBYTES        4    // Strobe bits per word

// Line geometry, direct mapped
`define CACHE_LINE_OFF_W    4    // 16 lines
`define CACHE_WORD_OFF_W    2    // 4 words per line
`define CACHE_TAG_W         (`CACHE_ADDR_W - `CACHE_LINE_OFF_W - `CACHE_WORD_OFF_W - $clog2(`CACHE_NBYTES))

// Write-through buffer, log2 of entries
`define CACHE_WTBUF_DEPTH_W 2

`endif

// ==== cache_pkg.sv ====
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

   // Address fields
   typedef logic [`CACHE_TAG_W-1:0]      tag_t;
   typedef logic [`CACHE_LINE_OFF_W-1:0] index_t;
   typedef logic [`CACHE_WORD_OFF_W-1:0] word_off_t;
   typedef logic [`CACHE_DATA_W-1:0]     data_t;
   typedef logic [`CACHE_NBYTES-1:0]     strb_t;

   typedef struct packed {
      tag_t      tag;
      index_t    index;
      word_off_t word;
   } waddr_t;                           // Word address, byte offset dropped

   typedef struct packed {
      tag_t   tag;
      index_t index;
   } line_addr_t;                       // Line address for refills

   typedef struct packed {
      waddr_t addr;
      data_t  data;
      strb_t  strb;
   } wtb_entry_t;                       // One pending write

   typedef enum logic [1:0] {
      BE_IDLE,
      BE_WRITE,                         // Drain one buffered word
      BE_FILL                           // Fetch the words of a line
   } be_state_t;

   // Low bits of the word address in the control space
   typedef enum logic [2:0] {
      CTRL_RD_HIT     = 3'd0,
      CTRL_RD_MISS    = 3'd1,
      CTRL_WR_HIT     = 3'd2,
      CTRL_WR_MISS    = 3'd3,
      CTRL_WTB_EMPTY  = 3'd4,
      CTRL_WTB_FULL   = 3'd5,
      CTRL_CNT_RST    = 3'd6,
      CTRL_INVALIDATE = 3'd7
   } ctrl_op_t;

endpackage

`default_nettype wire

// ==== cache_if.sv ====
`timescale 1ns/1ps
`default_nettype none

////////////////////
// Front end to cache memory
interface cache_fe_if;
   logic              data_req;
   cache_pkg::waddr_t data_addr;
   cache_pkg::data_t  data_wdata;
   cache_pkg::strb_t  data_wstrb;          // Any bit set means write
   cache_pkg::data_t  data_rdata;
   logic              data_ack;

   modport fe  (output data_req, data_addr, data_wdata, data_wstrb,
                input  data_rdata, data_ack);
   modport mem (input  data_req, data_addr, data_wdata, data_wstrb,
                output data_rdata, data_ack);
endinterface

// Front end to control block
interface cache_ctrl_if;
   logic                ctrl_req;
   cache_pkg::ctrl_op_t ctrl_op;
   cache_pkg::data_t    ctrl_rdata;
   logic                ctrl_ack;

   modport fe   (output ctrl_req, ctrl_op, input ctrl_rdata, ctrl_ack);
   modport ctrl (input ctrl_req, ctrl_op, output ctrl_rdata, ctrl_ack);
endinterface

////////////////////
// Cache memory to back end
interface cache_be_if;
   // Write channel, fed by the write-through buffer
   logic                  write_req;       // Buffer not empty
   cache_pkg::waddr_t     write_addr;
   cache_pkg::data_t      write_wdata;
   cache_pkg::strb_t      write_wstrb;
   logic                  write_ack;       // Pops one entry
   // Read channel, line refill
   logic                  replace_req;
   cache_pkg::line_addr_t replace_addr;
   logic                  replace;         // High for the whole refill
   logic                  read_req;        // One pulse per word
   cache_pkg::word_off_t  read_addr;
   cache_pkg::data_t      read_rdata;

   modport mem (output write_req, write_addr, write_wdata, write_wstrb,
                input  write_ack,
                output replace_req, replace_addr,
                input  replace, read_req, read_addr, read_rdata);
   modport be  (input  write_req, write_addr, write_wdata, write_wstrb,
                output write_ack,
                input  replace_req, replace_addr,
                output replace, read_req, read_addr, read_rdata);
endinterface

// Status and events between cache memory and control
interface cache_stat_if;
   logic wtbuf_empty;
   logic wtbuf_full;
   logic read_hit;
   logic read_miss;
   logic write_hit;
   logic write_miss;
   logic invalidate;                       // From control

   modport mem  (output wtbuf_empty, wtbuf_full, read_hit, read_miss,
                 write_hit, write_miss, input invalidate);
   modport ctrl (input  wtbuf_empty, wtbuf_full, read_hit, read_miss,
                 write_hit, write_miss, output invalidate);
endinterface

`default_nettype wire

// ==== front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module front_end
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     req,
   input  logic [`CACHE_ADDR_W:0]   addr,   // Top bit selects control space
   input  logic [`CACHE_DATA_W-1:0] wdata,
   input  logic [`CACHE_NBYTES-1:0] wstrb,
   output logic [`CACHE_DATA_W-1:0] rdata,
   output logic                     ack,
   cache_fe_if.fe                   data_bus,
   cache_ctrl_if.fe                 ctrl_bus
);

   logic              req_q;                // Request held
   logic              ctrl_sel_q;
   cache_pkg::waddr_t addr_q;
   cache_pkg::data_t  wdata_q;
   cache_pkg::strb_t  wstrb_q;
   logic              sample;

   assign sample = req & ~req_q;            // Only one request at a time

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         req_q <= 1'b0;
      else if (ack)
         req_q <= 1'b0;                     // Free for the next request
      else if (sample)
         req_q <= 1'b1;
   end

   // Payload capture
   always_ff @(posedge clk)
   begin
      if (sample)
      begin
         ctrl_sel_q <= addr[`CACHE_ADDR_W];
         addr_q     <= addr[`CACHE_ADDR_W-1 -: $bits(cache_pkg::waddr_t)];
         wdata_q    <= wdata;
         wstrb_q    <= wstrb;
      end
   end

   // Steering
   assign data_bus.data_req   = req_q & ~ctrl_sel_q;
   assign data_bus.data_addr  = addr_q;
   assign data_bus.data_wdata = wdata_q;
   assign data_bus.data_wstrb = wstrb_q;

   assign ctrl_bus.ctrl_req = req_q & ctrl_sel_q;
   assign ctrl_bus.ctrl_op  = cache_pkg::ctrl_op_t'(addr_q[$bits(cache_pkg::ctrl_op_t)-1:0]);

   // Only one side answers per request
   assign ack   = data_bus.data_ack | ctrl_bus.ctrl_ack;
   assign rdata = ctrl_bus.ctrl_ack ? ctrl_bus.ctrl_rdata : data_bus.data_rdata;

endmodule

`default_nettype wire

// ==== write_through_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module write_through_buffer
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  push,
   input  cache_pkg::wtb_entry_t push_data,
   input  logic                  pop,
   output cache_pkg::wtb_entry_t pop_data,
   output logic                  empty,
   output logic                  full
);

   // Pointers carry one wrap bit
   logic [`CACHE_WTBUF_DEPTH_W:0]   wr_ptr_q;
   logic [`CACHE_WTBUF_DEPTH_W:0]   rd_ptr_q;
   cache_pkg::wtb_entry_t           mem_q [2**`CACHE_WTBUF_DEPTH_W];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end
      else
      begin
         if (push && !full)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop && !empty)
            rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push && !full)
         mem_q[wr_ptr_q[`CACHE_WTBUF_DEPTH_W-1:0]] <= push_data;
   end

   assign pop_data = mem_q[rd_ptr_q[`CACHE_WTBUF_DEPTH_W-1:0]];   // Head entry

   // Same slot, wrap bits tell the two levels apart
   assign empty = (wr_ptr_q == rd_ptr_q);
   assign full  = (wr_ptr_q[`CACHE_WTBUF_DEPTH_W] != rd_ptr_q[`CACHE_WTBUF_DEPTH_W]) &&
                  (wr_ptr_q[`CACHE_WTBUF_DEPTH_W-1:0] == rd_ptr_q[`CACHE_WTBUF_DEPTH_W-1:0]);

endmodule

`default_nettype wire

// ==== cache_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_memory
(
   input  logic      clk,
   input  logic      rst_n,
   cache_fe_if.mem   fe_bus,
   cache_be_if.mem   be_bus,
   cache_stat_if.mem stat_bus
);

   localparam int NLINES = 2**`CACHE_LINE_OFF_W;

   ////////////////////
   // Arrays
   logic [NLINES-1:0]  valid_q;
   cache_pkg::tag_t    tag_arr [NLINES];
   cache_pkg::data_t   data_arr [NLINES * 2**`CACHE_WORD_OFF_W];

   logic                  ack_q;
   cache_pkg::data_t      rdata_q;
   logic                  replace_req_q;   // Refill outstanding
   logic                  fill_done_q;     // Answer the missed read next
   cache_pkg::tag_t       tag;
   cache_pkg::index_t     idx;
   logic                  is_write;
   logic                  hit;
   logic                  lookup;
   logic                  rd_hit_go;
   logic                  rd_miss_go;
   logic                  wr_go;
   logic                  last_word;
   logic                  wtb_empty;
   logic                  wtb_full;
   cache_pkg::wtb_entry_t wtb_in;
   cache_pkg::wtb_entry_t wtb_head;

   assign tag      = fe_bus.data_addr.tag;
   assign idx      = fe_bus.data_addr.index;
   assign is_write = |fe_bus.data_wstrb;
   assign hit      = valid_q[idx] & (tag_arr[idx] == tag);

   // No new decision while acking or refilling
   assign lookup     = fe_bus.data_req & ~ack_q & ~replace_req_q & ~fill_done_q;
   assign rd_hit_go  = lookup & ~is_write & hit;
   assign rd_miss_go = lookup & ~is_write & ~hit & wtb_empty;   // Earlier writes landed first
   assign wr_go      = lookup & is_write & ~wtb_full;           // Held request is back-pressure
   assign last_word  = be_bus.read_req & (be_bus.read_addr == '1);

   ////////////////////
   // Control state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ack_q         <= 1'b0;
         replace_req_q <= 1'b0;
         fill_done_q   <= 1'b0;
         valid_q       <= '0;
      end
      else
      begin
         ack_q       <= rd_hit_go | wr_go | fill_done_q;
         fill_done_q <= last_word;
         if (stat_bus.invalidate)
            valid_q <= '0;                 // Drop every line
         if (rd_miss_go)
            replace_req_q <= 1'b1;
         if (last_word)
         begin
            replace_req_q <= 1'b0;
            valid_q[idx]  <= 1'b1;
         end
      end
   end

   // Tag and data arrays
   always_ff @(posedge clk)
   begin
      if (last_word)
         tag_arr[idx] <= tag;
      if (be_bus.read_req)
         data_arr[{idx, be_bus.read_addr}] <= be_bus.read_rdata;   // Refill word
      else if (wr_go && hit)
      begin
         for (int b = 0; b < `CACHE_NBYTES; b++)
         begin
            if (fe_bus.data_wstrb[b])
               data_arr[{idx, fe_bus.data_addr.word}][8*b +: 8] <= fe_bus.data_wdata[8*b +: 8];
         end
      end
      if (rd_hit_go || fill_done_q)
         rdata_q <= data_arr[{idx, fe_bus.data_addr.word}];
   end

   assign fe_bus.data_ack   = ack_q;
   assign fe_bus.data_rdata = rdata_q;

   ////////////////////
   // Write-through path
   assign wtb_in.addr = fe_bus.data_addr;
   assign wtb_in.data = fe_bus.data_wdata;
   assign wtb_in.strb = fe_bus.data_wstrb;

   write_through_buffer u_wtbuf
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (wr_go),
      .push_data (wtb_in),
      .pop       (be_bus.write_ack),
      .pop_data  (wtb_head),
      .empty     (wtb_empty),
      .full      (wtb_full)
   );

   assign be_bus.write_req   = ~wtb_empty;
   assign be_bus.write_addr  = wtb_head.addr;
   assign be_bus.write_wdata = wtb_head.data;
   assign be_bus.write_wstrb = wtb_head.strb;

   assign be_bus.replace_req       = replace_req_q;
   assign be_bus.replace_addr.tag   = tag;    // Request is held through the refill
   assign be_bus.replace_addr.index = idx;

   // Events, one pulse per accepted request
   assign stat_bus.wtbuf_empty = wtb_empty;
   assign stat_bus.wtbuf_full  = wtb_full;
   assign stat_bus.read_hit    = rd_hit_go;
   assign stat_bus.read_miss   = rd_miss_go;
   assign stat_bus.write_hit   = wr_go & hit;
   assign stat_bus.write_miss  = wr_go & ~hit;

endmodule

`default_nettype wire

// ==== back_end_native.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module back_end_native
(
   input  logic                     clk,
   input  logic                     rst_n,
   output logic                     mem_req,
   output logic [`CACHE_ADDR_W-1:0] mem_addr,
   output logic [`CACHE_DATA_W-1:0] mem_wdata,
   output logic [`CACHE_NBYTES-1:0] mem_wstrb,
   input  logic [`CACHE_DATA_W-1:0] mem_rdata,
   input  logic                     mem_ack,
   cache_be_if.be                   be_bus
);

   cache_pkg::be_state_t state_q;
   cache_pkg::word_off_t cnt_q;              // Word being fetched

   ////////////////////
   // FSM
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= cache_pkg::BE_IDLE;
         cnt_q   <= '0;
      end
      else
      begin
         case (state_q)
            cache_pkg::BE_IDLE:
            begin
               if (be_bus.write_req)
                  state_q <= cache_pkg::BE_WRITE;   // Writes go before fills
               else if (be_bus.replace_req)
               begin
                  state_q <= cache_pkg::BE_FILL;
                  cnt_q   <= '0;
               end
            end
            cache_pkg::BE_WRITE:
            begin
               if (mem_ack)
                  state_q <= cache_pkg::BE_IDLE;   // Recheck buffer and fill
            end
            cache_pkg::BE_FILL:
            begin
               if (mem_ack)
               begin
                  cnt_q <= cnt_q + 1'b1;
                  if (cnt_q == '1)
                     state_q <= cache_pkg::BE_IDLE;
               end
            end
            default: state_q <= cache_pkg::BE_IDLE;
         endcase
      end
   end

   // Memory port, held stable until mem_ack
   assign mem_req   = (state_q != cache_pkg::BE_IDLE);
   assign mem_addr  = (state_q == cache_pkg::BE_FILL) ?
                      {be_bus.replace_addr, cnt_q, {$clog2(`CACHE_NBYTES){1'b0}}} :
                      {be_bus.write_addr, {$clog2(`CACHE_NBYTES){1'b0}}};
   assign mem_wdata = be_bus.write_wdata;
   assign mem_wstrb = (state_q == cache_pkg::BE_WRITE) ? be_bus.write_wstrb : '0;   // Reads

   assign be_bus.write_ack  = (state_q == cache_pkg::BE_WRITE) & mem_ack;
   assign be_bus.replace    = (state_q == cache_pkg::BE_FILL);
   assign be_bus.read_req   = (state_q == cache_pkg::BE_FILL) & mem_ack;
   assign be_bus.read_addr  = cnt_q;
   assign be_bus.read_rdata = mem_rdata;

endmodule

`default_nettype wire

// ==== cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_control
(
   input  logic       clk,
   input  logic       rst_n,
   cache_ctrl_if.ctrl ctrl_bus,
   cache_stat_if.ctrl stat_bus
);

   logic             ack_q;
   logic             inv_q;
   cache_pkg::data_t rdata_q;
   cache_pkg::data_t cnt_q [4];   // Ordered as the opcodes RD_HIT to WR_MISS
   logic [3:0]       event_v;
   logic             lookup;

   assign lookup  = ctrl_bus.ctrl_req & ~ack_q;
   assign event_v = {stat_bus.write_miss, stat_bus.write_hit,
                     stat_bus.read_miss, stat_bus.read_hit};

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ack_q <= 1'b0;
         inv_q <= 1'b0;
         for (int i = 0; i < 4; i++)
            cnt_q[i] <= '0;
      end
      else
      begin
         ack_q <= lookup;
         inv_q <= lookup & (ctrl_bus.ctrl_op == cache_pkg::CTRL_INVALIDATE);   // One pulse
         for (int i = 0; i < 4; i++)
         begin
            if (lookup && ctrl_bus.ctrl_op == cache_pkg::CTRL_CNT_RST)
               cnt_q[i] <= '0;                  // Clear beats a same-cycle event
            else if (event_v[i])
               cnt_q[i] <= cnt_q[i] + 1'b1;
         end
      end
   end

   ////////////////////
   // Read data
   always_ff @(posedge clk)
   begin
      if (lookup)
      begin
         case (ctrl_bus.ctrl_op)
            cache_pkg::CTRL_RD_HIT,
            cache_pkg::CTRL_RD_MISS,
            cache_pkg::CTRL_WR_HIT,
            cache_pkg::CTRL_WR_MISS:   rdata_q <= cnt_q[ctrl_bus.ctrl_op[1:0]];
            cache_pkg::CTRL_WTB_EMPTY: rdata_q <= cache_pkg::data_t'(stat_bus.wtbuf_empty);
            cache_pkg::CTRL_WTB_FULL:  rdata_q <= cache_pkg::data_t'(stat_bus.wtbuf_full);
            default:                   rdata_q <= '0;   // Commands return zero
         endcase
      end
   end

   assign ctrl_bus.ctrl_ack   = ack_q;
   assign ctrl_bus.ctrl_rdata = rdata_q;
   assign stat_bus.invalidate = inv_q;

endmodule

`default_nettype wire

// ==== iob_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module iob_cache
(
   input  logic                     clk,
   input  logic                     rst_n,
   // Processor side
   input  logic                     req,
   input  logic [`CACHE_ADDR_W:0]   addr,        // Extra top bit for control space
   input  logic [`CACHE_DATA_W-1:0] wdata,
   input  logic [`CACHE_NBYTES-1:0] wstrb,
   output logic [`CACHE_DATA_W-1:0] rdata,
   output logic                     ack,
   // Memory side
   output logic                     mem_req,
   output logic [`CACHE_ADDR_W-1:0] mem_addr,
   output logic [`CACHE_DATA_W-1:0] mem_wdata,
   output logic [`CACHE_NBYTES-1:0] mem_wstrb,
   input  logic [`CACHE_DATA_W-1:0] mem_rdata,
   input  logic                     mem_ack
);

   cache_fe_if   fe_bus ();
   cache_ctrl_if ctrl_bus ();
   cache_be_if   be_bus ();
   cache_stat_if stat_bus ();

   ////////////////////
   // Request capture and steering
   front_end u_front_end
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .addr     (addr),
      .wdata    (wdata),
      .wstrb    (wstrb),
      .rdata    (rdata),
      .ack      (ack),
      .data_bus (fe_bus.fe),
      .ctrl_bus (ctrl_bus.fe)
   );

   // Arrays and write-through buffer
   cache_memory u_cache_memory
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .fe_bus   (fe_bus.mem),
      .be_bus   (be_bus.mem),
      .stat_bus (stat_bus.mem)
   );

   // Memory port
   back_end_native u_back_end
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .mem_req   (mem_req),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ack   (mem_ack),
      .be_bus    (be_bus.be)
   );

   // Counters and invalidate
   cache_control u_cache_control
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .ctrl_bus (ctrl_bus.ctrl),
      .stat_bus (stat_bus.ctrl)
   );

endmodule

`default_nettype wire

// ==== tb_iob_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module tb_iob_cache;

   logic                     clk;
   logic                     rst_n;
   logic                     req;
   logic [`CACHE_ADDR_W:0]   addr;
   logic [`CACHE_DATA_W-1:0] wdata;
   logic [`CACHE_NBYTES-1:0] wstrb;
   logic [`CACHE_DATA_W-1:0] rdata;
   logic                     ack;
   logic                     mem_req;
   logic [`CACHE_ADDR_W-1:0] mem_addr;
   logic [`CACHE_DATA_W-1:0] mem_wdata;
   logic [`CACHE_NBYTES-1:0] mem_wstrb;
   logic [`CACHE_DATA_W-1:0] mem_rdata;
   logic                     mem_ack;

   logic [31:0] mem_model [4096];   // Word array behind the memory port
   logic [31:0] ref_mem [4096];     // Expected memory contents as writes are issued
   logic [15:0] ref_valid;          // Expected valid bits per line
   logic [7:0]  ref_tag [16];
   logic [31:0] exp_cnt [4];        // RD_HIT, RD_MISS, WR_HIT, WR_MISS
   logic [31:0] rng_state;
   int          issued;             // Accesses started so far
   int          cycles;

   iob_cache u_iob_cache
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .addr      (addr),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .rdata     (rdata),
      .ack       (ack),
      .mem_req   (mem_req),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ack   (mem_ack)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   ////////////////////
   // Helpers
   function logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function logic [31:0] merge_bytes(input logic [31:0] old_word, input logic [31:0] new_word,
                                     input logic [3:0] strb);
      logic [31:0] merged;
      merged = old_word;
      for (int b = 0; b < 4; b++)
      begin
         if (strb[b])
            merged[8*b +: 8] = new_word[8*b +: 8];
      end
      return merged;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("mismatch %s: expected %h actual %h", name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "wrong value in %s", name);
      end
   endtask

   // One request held until ack
   task automatic bus_access(input logic ctrl_space, input logic [15:0] byte_addr,
                             input logic [31:0] data, input logic [3:0] strb,
                             output logic [31:0] result);
      @(posedge clk);
      #10;
      req    = 1'b1;
      addr   = {ctrl_space, byte_addr};
      wdata  = data;
      wstrb  = strb;
      issued = issued + 1;
      do
         @(negedge clk);
      while (ack !== 1'b1);   // Ack and rdata are settled mid-cycle
      result = rdata;
      @(posedge clk);
      #10;
      req   = 1'b0;
      wstrb = '0;
   endtask

   task automatic ctrl_access(input cache_pkg::ctrl_op_t op, output logic [31:0] result);
      bus_access(1'b1, {11'b0, op, 2'b00}, '0, '0, result);
   endtask

   // Direct mapped lookup on the expected tags before the data compare
   task automatic read_word(input string name, input logic [15:0] byte_addr);
      logic [31:0] result;
      logic [3:0]  idx;
      idx = byte_addr[7:4];
      if (ref_valid[idx] && ref_tag[idx] == byte_addr[15:8])
         exp_cnt[0] = exp_cnt[0] + 1;
      else
      begin
         exp_cnt[1]     = exp_cnt[1] + 1;
         ref_valid[idx] = 1'b1;                   // Line now allocated
         ref_tag[idx]   = byte_addr[15:8];
      end
      bus_access(1'b0, byte_addr, '0, '0, result);
      check_value(name, ref_mem[byte_addr[13:2]], result);
   endtask

   task automatic write_word(input logic [15:0] byte_addr, input logic [31:0] data,
                             input logic [3:0] strb);
      logic [31:0] result;
      logic [3:0]  idx;
      idx = byte_addr[7:4];
      if (ref_valid[idx] && ref_tag[idx] == byte_addr[15:8])
         exp_cnt[2] = exp_cnt[2] + 1;
      else
         exp_cnt[3] = exp_cnt[3] + 1;             // No allocation on a write miss
      ref_mem[byte_addr[13:2]] = merge_bytes(ref_mem[byte_addr[13:2]], data, strb);
      bus_access(1'b0, byte_addr, data, strb, result);
   endtask

   task automatic wait_buffer_drained();
      logic [31:0] status;
      int          polls;
      status = '0;
      polls  = 0;
      while (status[0] !== 1'b1 && polls < 50)
      begin
         ctrl_access(cache_pkg::CTRL_WTB_EMPTY, status);
         polls = polls + 1;
      end
      if (status[0] !== 1'b1)
      begin
         $display("write-through buffer still not empty after %0d status reads", polls);
         $display("TEST FAILED");
         $fatal(1, "buffer never drained");
      end
   endtask

   task automatic check_counters(input string name);
      logic [31:0] value;
      for (int i = 0; i < 4; i++)
      begin
         ctrl_access(cache_pkg::ctrl_op_t'(i), value);
         check_value(name, exp_cnt[i], value);
      end
   endtask

   task automatic compare_model_word(input string name, input logic [15:0] byte_addr);
      check_value(name, ref_mem[byte_addr[13:2]], mem_model[byte_addr[13:2]]);
   endtask

   ////////////////////
   // Directed tests
   task automatic read_miss_then_hit();
      read_word("read_miss_then_hit", 16'h0120);    // Tag 1, line 2
      for (int w = 0; w < 4; w++)
         read_word("read_miss_then_hit", 16'h0120 + 16'(w * 4));
      check_counters("read_miss_then_hit");
   endtask

   task automatic write_through_strobes();
      write_word(16'h0124, 32'ha5a5_5a5a, 4'b0101);   // Bytes 0 and 2 only
      read_word("write_through_strobes", 16'h0124);
      wait_buffer_drained();
      compare_model_word("write_through_strobes", 16'h0124);
      check_counters("write_through_strobes");
   endtask

   task automatic write_miss_no_allocate();
      write_word(16'h0238, 32'h1234_5678, 4'hf);
      read_word("write_miss_no_allocate", 16'h0238);   // Fill sees the landed write
      compare_model_word("write_miss_no_allocate", 16'h0238);
      check_counters("write_miss_no_allocate");
   endtask

   task automatic conflict_eviction();
      for (int i = 0; i < 3; i++)
      begin
         read_word("conflict_eviction", 16'h0354);   // Line 5 under tags 03 and 13
         read_word("conflict_eviction", 16'h1354);
      end
      check_counters("conflict_eviction");
   endtask

   task automatic invalidate_all();
      logic [31:0] unused;
      read_word("invalidate_all", 16'h0128);
      ctrl_access(cache_pkg::CTRL_INVALIDATE, unused);
      ref_valid = '0;
      read_word("invalidate_all", 16'h0128);      // Miss once
      read_word("invalidate_all", 16'h0128);      // Then hit
      check_counters("invalidate_all");
   endtask

   task automatic backpressure_and_counter_reset();
      logic [31:0] unused;
      for (int i = 0; i < 6; i++)
         write_word(16'h0400 + 16'((i % 4) * 4), next_random(), 4'hf);   // Two words rewritten
      wait_buffer_drained();
      for (int w = 0; w < 4; w++)
         compare_model_word("backpressure_and_counter_reset", 16'h0400 + 16'(w * 4));
      check_counters("backpressure_and_counter_reset");
      ctrl_access(cache_pkg::CTRL_CNT_RST, unused);
      for (int i = 0; i < 4; i++)
         exp_cnt[i] = '0;
      check_counters("backpressure_and_counter_reset");
   endtask

   ////////////////////
   // Memory model answering in 1 to 4 cycles per word
   initial
   begin : memory_model
      int unsigned wait_cnt;
      logic        busy;
      busy     = 1'b0;
      wait_cnt = 0;
      forever
      begin
         @(posedge clk);
         #10;
         mem_ack = 1'b0;
         if (mem_req === 1'b1)
         begin
            if (!busy)
            begin
               busy     = 1'b1;
               wait_cnt = next_random() >> 30;   // Top two bits give 0 to 3 extra cycles
            end
            if (wait_cnt == 0)
            begin
               if (|mem_wstrb)
                  mem_model[mem_addr[13:2]] = merge_bytes(mem_model[mem_addr[13:2]],
                                                          mem_wdata, mem_wstrb);
               else
                  mem_rdata = mem_model[mem_addr[13:2]];
               mem_ack = 1'b1;
               busy    = 1'b0;
            end
            else
               wait_cnt = wait_cnt - 1;
         end
      end
   end

   // Watchdog allowing 200 cycles per access issued
   initial
   begin : watchdog
      while (cycles <= 200 * (issued + 1))
      begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      $display("watchdog expired after %0d cycles, an access never got its ack", cycles);
      $display("TEST FAILED");
      $fatal(1, "run stopped by watchdog");
   end

   initial
   begin
      req       = 1'b0;
      addr      = '0;
      wdata     = '0;
      wstrb     = '0;
      mem_rdata = '0;
      mem_ack   = 1'b0;
      rst_n     = 1'b0;
      rng_state = 32'h4c2;
      ref_valid = '0;
      for (int i = 0; i < 4; i++)
         exp_cnt[i] = '0;
      for (int i = 0; i < 4096; i++)
      begin
         mem_model[i] = next_random();
         ref_mem[i]   = mem_model[i];
      end
      repeat (5) @(posedge clk);
      #10;
      rst_n = 1'b1;

      read_miss_then_hit();
      write_through_strobes();
      write_miss_no_allocate();
      conflict_eviction();
      invalidate_all();
      backpressure_and_counter_reset();

      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
cache_pkg.sv
cache_if.sv
front_end.sv
write_through_buffer.sv
cache_memory.sv
back_end_native.sv
cache_control.sv
iob_cache.sv
tb_iob_cache.sv

// ==== Bender.yml ====
package:
  name: iob_cache

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - cache_if.sv
      - front_end.sv
      - write_through_buffer.sv
      - cache_memory.sv
      - back_end_native.sv
      - cache_control.sv
      - iob_cache.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_iob_cache.sv
